//--- logic/scope_pkg.sv
`default_nettype none

package scope_pkg;

  localparam int SAMPLE_W = 8;  // adc word

  // raster, one pixel per sys_clk
  localparam int H_ACTIVE     = 128;
  localparam int H_TOTAL      = 160;
  localparam int H_SYNC_START = 136;
  localparam int H_SYNC_END   = 144;
  localparam int V_ACTIVE     = 64;
  localparam int V_TOTAL      = 72;
  localparam int V_SYNC_START = 66;
  localparam int V_SYNC_END   = 68;
  localparam int X_W          = 8;
  localparam int Y_W          = 7;

  localparam int BUF_DEPTH = 128;  // one sample per visible column
  localparam int BUF_AW    = 7;
  localparam int GRID_STEP = 16;

  localparam logic [23:0] COLOR_BG   = 24'h000000;
  localparam logic [23:0] COLOR_GRID = 24'h808080;
  localparam logic [23:0] COLOR_WAVE = 24'hff0000;

  localparam int MEAS_WINDOW = 256;  // input samples per result
  localparam int MEAS_CW     = 8;

  typedef enum logic [1:0] {
    CAP_IDLE,
    CAP_WAIT_TRIG,
    CAP_FILL,
    CAP_HOLD
  } capture_state_t;

endpackage

`default_nettype wire

//--- logic/sample_decimator.sv
`timescale 1ns/10ps
`default_nettype none

module sample_decimator (
  input  wire       sys_clk,
  input  wire       sys_rst_n,
  input  wire [9:0] i_deci_rate,  // 0 and 1 both keep every sample
  output logic      o_keep_stb
);

  logic [9:0] cnt;

  // count down, reload and strobe on the wrap
  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      cnt        <= '0;
      o_keep_stb <= 1'b0;
    end else if (cnt <= 10'd1) begin
      cnt        <= i_deci_rate;
      o_keep_stb <= 1'b1;
    end else begin
      cnt        <= cnt - 1'b1;
      o_keep_stb <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- logic/trigger_capture.sv
`timescale 1ns/10ps
`default_nettype none

module trigger_capture
  import scope_pkg::*;
(
  input  wire                 sys_clk,
  input  wire                 sys_rst_n,
  input  wire  [SAMPLE_W-1:0] i_ad_data,
  input  wire                 i_keep_stb,
  input  wire  [SAMPLE_W-1:0] i_trig_level,
  input  wire                 i_trig_edge,   // 1 = rising
  input  wire                 i_run_key,     // one-cycle pulse
  input  wire                 i_frame_start,
  output logic                o_buf_wr,
  output logic [BUF_AW-1:0]   o_buf_addr,
  output logic [SAMPLE_W-1:0] o_buf_data,
  output logic                o_capture_done,
  output logic                o_running
);

  capture_state_t      state;
  logic [SAMPLE_W-1:0] prev_q;  // last kept sample
  logic                prev_ok;
  logic                run_q;
  logic                trig_hit;
  logic                last_wr;

  always_comb begin
    if (i_trig_edge) begin
      trig_hit = prev_ok && (prev_q < i_trig_level) && (i_ad_data >= i_trig_level);
    end else begin
      trig_hit = prev_ok && (prev_q >= i_trig_level) && (i_ad_data < i_trig_level);
    end
  end

  assign last_wr   = o_buf_wr && (o_buf_addr == BUF_AW'(BUF_DEPTH - 1));
  assign o_running = run_q;

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      run_q   <= 1'b1;  // running out of reset
      prev_ok <= 1'b0;
    end else begin
      if (i_run_key) run_q <= !run_q;
      if (i_keep_stb) prev_ok <= 1'b1;
    end
  end

  // kept sample doubles as write data
  always_ff @(posedge sys_clk) begin
    if (i_keep_stb) begin
      prev_q     <= i_ad_data;
      o_buf_data <= i_ad_data;
    end
  end

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      state          <= CAP_IDLE;
      o_buf_wr       <= 1'b0;
      o_buf_addr     <= '0;
      o_capture_done <= 1'b0;
    end else begin
      o_buf_wr       <= 1'b0;
      o_capture_done <= 1'b0;
      case (state)
        CAP_IDLE: if (run_q) state <= CAP_WAIT_TRIG;
        CAP_WAIT_TRIG: begin
          if (!run_q) begin
            state <= CAP_IDLE;
          end else if (i_keep_stb && trig_hit) begin
            state      <= CAP_FILL;
            o_buf_wr   <= 1'b1;  // triggering sample goes to slot 0
            o_buf_addr <= '0;
          end
        end
        CAP_FILL: begin
          if (!run_q) begin
            state <= CAP_IDLE;  // stop freezes mid-record
          end else if (last_wr) begin
            state          <= CAP_HOLD;
            o_capture_done <= 1'b1;
          end else if (i_keep_stb) begin
            o_buf_wr   <= 1'b1;
            o_buf_addr <= o_buf_addr + 1'b1;
          end
        end
        CAP_HOLD: begin
          // keep the record steady until the frame boundary
          if (i_frame_start) state <= run_q ? CAP_WAIT_TRIG : CAP_IDLE;
        end
        default: state <= CAP_IDLE;
      endcase
    end
  end

  a_wr_in_fill: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    o_buf_wr |-> state == CAP_FILL);

  // last slot written ends the record, no wrap back to 0
  a_no_wrap: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    last_wr |=> !o_buf_wr && o_capture_done);

endmodule

`default_nettype wire

//--- logic/wave_measure.sv
`timescale 1ns/10ps
`default_nettype none

module wave_measure
  import scope_pkg::*;
(
  input  wire                 sys_clk,
  input  wire                 sys_rst_n,
  input  wire  [SAMPLE_W-1:0] i_ad_data,
  input  wire  [SAMPLE_W-1:0] i_trig_level,
  output logic [SAMPLE_W-1:0] o_max,
  output logic [SAMPLE_W-1:0] o_min,
  output logic [SAMPLE_W-1:0] o_vpp,
  output logic [MEAS_CW-1:0]  o_cross_count,
  output logic                o_meas_valid
);

  logic [$clog2(MEAS_WINDOW)-1:0] win_cnt;
  logic [SAMPLE_W-1:0]            run_max, run_min, prev_q;
  logic [MEAS_CW-1:0]             run_cnt;
  logic [SAMPLE_W-1:0]            max_nx, min_nx;
  logic [MEAS_CW-1:0]             cnt_nx;
  logic                           first, last, cross_hit;

  assign first     = (win_cnt == '0);  // window restarts here
  assign last      = (win_cnt == $bits(win_cnt)'(MEAS_WINDOW - 1));
  // pairs inside the window only
  assign cross_hit = !first && (prev_q < i_trig_level) && (i_ad_data >= i_trig_level);
  assign max_nx    = (first || i_ad_data > run_max) ? i_ad_data : run_max;
  assign min_nx    = (first || i_ad_data < run_min) ? i_ad_data : run_min;
  assign cnt_nx    = (first ? '0 : run_cnt) + MEAS_CW'(cross_hit);

  always_ff @(posedge sys_clk) begin
    prev_q  <= i_ad_data;
    run_max <= max_nx;
    run_min <= min_nx;
    run_cnt <= cnt_nx;
  end

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      win_cnt       <= '0;
      o_meas_valid  <= 1'b0;
      o_max         <= '0;
      o_min         <= '0;
      o_vpp         <= '0;
      o_cross_count <= '0;
    end else begin
      win_cnt      <= last ? '0 : win_cnt + 1'b1;
      o_meas_valid <= last;
      if (last) begin  // latched and held until the next window
        o_max         <= max_nx;
        o_min         <= min_nx;
        o_vpp         <= max_nx - min_nx;
        o_cross_count <= cnt_nx;
      end
    end
  end

  // 9-bit compare catches a min above the max
  a_vpp: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    o_meas_valid |-> {1'b0, o_vpp} == {1'b0, o_max} - {1'b0, o_min});

endmodule

`default_nettype wire

//--- logic/video_timing.sv
`timescale 1ns/10ps
`default_nettype none

module video_timing
  import scope_pkg::*;
(
  input  wire            sys_clk,
  input  wire            sys_rst_n,
  output logic           o_hs,
  output logic           o_vs,
  output logic           o_de,
  output logic [X_W-1:0] o_x,
  output logic [Y_W-1:0] o_y,
  output logic           o_frame_start
);

  logic [X_W-1:0] h_cnt;
  logic [Y_W-1:0] v_cnt;
  logic           h_end, v_end;

  assign h_end = (h_cnt == X_W'(H_TOTAL - 1));
  assign v_end = (v_cnt == Y_W'(V_TOTAL - 1));

  // reset parks on the last pixel so (0,0) follows release
  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      h_cnt <= X_W'(H_TOTAL - 1);
      v_cnt <= Y_W'(V_TOTAL - 1);
    end else if (h_end) begin
      h_cnt <= '0;
      v_cnt <= v_end ? '0 : v_cnt + 1'b1;
    end else begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  assign o_hs = (h_cnt >= X_W'(H_SYNC_START)) && (h_cnt < X_W'(H_SYNC_END));
  assign o_vs = (v_cnt >= Y_W'(V_SYNC_START)) && (v_cnt < Y_W'(V_SYNC_END));
  assign o_de = (h_cnt < X_W'(H_ACTIVE)) && (v_cnt < Y_W'(V_ACTIVE));
  assign o_x  = h_cnt;
  assign o_y  = v_cnt;
  assign o_frame_start = (h_cnt == '0) && (v_cnt == '0);

endmodule

`default_nettype wire

//--- logic/grid_overlay.sv
`timescale 1ns/10ps
`default_nettype none

module grid_overlay
  import scope_pkg::*;
(
  input  wire            sys_clk,
  input  wire            sys_rst_n,
  input  wire            i_hs,
  input  wire            i_vs,
  input  wire            i_de,
  input  wire  [X_W-1:0] i_x,
  input  wire  [Y_W-1:0] i_y,
  output logic           o_hs,
  output logic           o_vs,
  output logic           o_de,
  output logic [X_W-1:0] o_x,
  output logic [Y_W-1:0] o_y,
  output logic [23:0]    o_rgb
);

  logic on_grid;

  // graticule plus closing right and bottom edges
  assign on_grid = ((i_x % X_W'(GRID_STEP)) == '0) || ((i_y % Y_W'(GRID_STEP)) == '0) ||
                   (i_x == X_W'(H_ACTIVE - 1)) || (i_y == Y_W'(V_ACTIVE - 1));

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      o_hs <= 1'b0;
      o_vs <= 1'b0;
      o_de <= 1'b0;
    end else begin
      o_hs <= i_hs;
      o_vs <= i_vs;
      o_de <= i_de;
    end
  end

  always_ff @(posedge sys_clk) begin
    o_x   <= i_x;
    o_y   <= i_y;
    o_rgb <= !i_de ? 24'h000000 : (on_grid ? COLOR_GRID : COLOR_BG);  // black in blanking
  end

endmodule

`default_nettype wire

//--- logic/wave_overlay.sv
`timescale 1ns/10ps
`default_nettype none

module wave_overlay
  import scope_pkg::*;
(
  input  wire                 sys_clk,
  input  wire                 sys_rst_n,
  input  wire                 i_buf_wr,
  input  wire  [BUF_AW-1:0]   i_buf_addr,
  input  wire  [SAMPLE_W-1:0] i_buf_data,
  input  wire                 i_hs,
  input  wire                 i_vs,
  input  wire                 i_de,
  input  wire  [X_W-1:0]      i_x,
  input  wire  [Y_W-1:0]      i_y,
  input  wire  [23:0]         i_rgb,
  output logic                o_hs,
  output logic                o_vs,
  output logic                o_de,
  output logic [23:0]         o_rgb
);

  logic [SAMPLE_W-1:0] mem [BUF_DEPTH];  // one record
  logic [SAMPLE_W-1:0] rd_q;
  logic [Y_W-1:0]      y_q;
  logic [23:0]         rgb_q;
  logic [Y_W-1:0]      trace_row;
  logic                on_trace;

  always_ff @(posedge sys_clk) begin
    if (i_buf_wr) mem[i_buf_addr] <= i_buf_data;
  end

  // column read lines up with the delayed video
  always_ff @(posedge sys_clk) begin
    rd_q  <= mem[i_x[BUF_AW-1:0]];
    y_q   <= i_y;
    rgb_q <= i_rgb;
  end

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      o_hs <= 1'b0;
      o_vs <= 1'b0;
      o_de <= 1'b0;
    end else begin
      o_hs <= i_hs;
      o_vs <= i_vs;
      o_de <= i_de;
    end
  end

  // top six bits inverted, full scale lands on line 0
  assign trace_row = {1'b0, ~rd_q[SAMPLE_W-1:SAMPLE_W-6]};
  assign on_trace  = o_de && (y_q == trace_row);
  assign o_rgb     = on_trace ? COLOR_WAVE : rgb_q;

endmodule

`default_nettype wire

//--- logic/scope_top.sv
`timescale 1ns/10ps
`default_nettype none

module scope_top
  import scope_pkg::*;
(
  input  wire                 sys_clk,
  input  wire                 sys_rst_n,
  input  wire  [SAMPLE_W-1:0] i_ad_data,
  input  wire  [SAMPLE_W-1:0] i_trig_level,
  input  wire  [9:0]          i_deci_rate,
  input  wire                 i_trig_edge,
  input  wire                 i_run_key,
  output wire                 o_hs,
  output wire                 o_vs,
  output wire                 o_de,
  output wire  [23:0]         o_rgb,
  output wire  [SAMPLE_W-1:0] o_max,
  output wire  [SAMPLE_W-1:0] o_min,
  output wire  [SAMPLE_W-1:0] o_vpp,
  output wire  [MEAS_CW-1:0]  o_cross_count,
  output wire                 o_meas_valid,
  output wire                 o_capture_done,
  output wire                 o_running
);

  wire                keep_stb;
  wire                buf_wr;
  wire [BUF_AW-1:0]   buf_addr;
  wire [SAMPLE_W-1:0] buf_data;
  wire                vt_hs, vt_vs, vt_de, frame_start;
  wire [X_W-1:0]      vt_x, grid_x;
  wire [Y_W-1:0]      vt_y, grid_y;
  wire                grid_hs, grid_vs, grid_de;
  wire [23:0]         grid_rgb;

  wave_measure u_wave_measure (
    .sys_clk(sys_clk), .sys_rst_n(sys_rst_n), .i_ad_data(i_ad_data),
    .i_trig_level(i_trig_level), .o_max(o_max), .o_min(o_min), .o_vpp(o_vpp),
    .o_cross_count(o_cross_count), .o_meas_valid(o_meas_valid)
  );

  sample_decimator u_sample_decimator (
    .sys_clk(sys_clk), .sys_rst_n(sys_rst_n), .i_deci_rate(i_deci_rate),
    .o_keep_stb(keep_stb)
  );

  trigger_capture u_trigger_capture (
    .sys_clk(sys_clk), .sys_rst_n(sys_rst_n), .i_ad_data(i_ad_data),
    .i_keep_stb(keep_stb), .i_trig_level(i_trig_level), .i_trig_edge(i_trig_edge),
    .i_run_key(i_run_key), .i_frame_start(frame_start), .o_buf_wr(buf_wr),
    .o_buf_addr(buf_addr), .o_buf_data(buf_data), .o_capture_done(o_capture_done),
    .o_running(o_running)
  );

  video_timing u_video_timing (  // stands in for the hdmi block
    .sys_clk(sys_clk), .sys_rst_n(sys_rst_n), .o_hs(vt_hs), .o_vs(vt_vs), .o_de(vt_de),
    .o_x(vt_x), .o_y(vt_y), .o_frame_start(frame_start)
  );

  grid_overlay u_grid_overlay (
    .sys_clk(sys_clk), .sys_rst_n(sys_rst_n), .i_hs(vt_hs), .i_vs(vt_vs), .i_de(vt_de),
    .i_x(vt_x), .i_y(vt_y), .o_hs(grid_hs), .o_vs(grid_vs), .o_de(grid_de),
    .o_x(grid_x), .o_y(grid_y), .o_rgb(grid_rgb)
  );

  wave_overlay u_wave_overlay (
    .sys_clk(sys_clk), .sys_rst_n(sys_rst_n), .i_buf_wr(buf_wr), .i_buf_addr(buf_addr),
    .i_buf_data(buf_data), .i_hs(grid_hs), .i_vs(grid_vs), .i_de(grid_de),
    .i_x(grid_x), .i_y(grid_y), .i_rgb(grid_rgb), .o_hs(o_hs), .o_vs(o_vs),
    .o_de(o_de), .o_rgb(o_rgb)
  );

endmodule

`default_nettype wire

//--- tests/scope_tb.sv
`timescale 1ns/10ps
`default_nettype none

module scope_tb
  import scope_pkg::*;
();

  logic        sys_clk, sys_rst_n;
  logic [7:0]  i_ad_data, i_trig_level;
  logic [9:0]  i_deci_rate;
  logic        i_trig_edge, i_run_key;
  wire         o_hs, o_vs, o_de, o_meas_valid, o_capture_done, o_running;
  wire  [23:0] o_rgb;
  wire  [7:0]  o_max, o_min, o_vpp, o_cross_count;

  int          errors, tests, failed_tests, meas_seen, mk;
  logic [1:0]  mode;  // 0 const, 1 random, 2 ramp up, 3 ramp down
  logic [7:0]  const_v, ramp_v;
  logic        stopped;
  logic [7:0]  m_max, m_min, m_prev, e_max, e_min;
  logic [MEAS_CW-1:0] m_cnt, e_cnt;
  logic        m_valid;
  logic [7:0]  rec [BUF_DEPTH];  // expected record

  scope_top uut (
    .sys_clk(sys_clk), .sys_rst_n(sys_rst_n), .i_ad_data(i_ad_data),
    .i_trig_level(i_trig_level), .i_deci_rate(i_deci_rate), .i_trig_edge(i_trig_edge),
    .i_run_key(i_run_key), .o_hs(o_hs), .o_vs(o_vs), .o_de(o_de), .o_rgb(o_rgb),
    .o_max(o_max), .o_min(o_min), .o_vpp(o_vpp), .o_cross_count(o_cross_count),
    .o_meas_valid(o_meas_valid), .o_capture_done(o_capture_done), .o_running(o_running)
  );

  initial sys_clk = 1'b0;
  always #20 sys_clk = ~sys_clk;

  // sample source
  always @(posedge sys_clk) begin
    case (mode)
      2'd1: i_ad_data <= 8'($urandom);
      2'd2: begin
        i_ad_data <= ramp_v;
        ramp_v    <= ramp_v + 8'd1;
      end
      2'd3: begin
        i_ad_data <= ramp_v;
        ramp_v    <= ramp_v - 8'd1;
      end
      default: i_ad_data <= const_v;
    endcase
  end

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (exp === got) else begin
      errors++;
      $display("error %0t %s expected %0h got %0h", $time, name, exp, got);
    end
  endtask

  task automatic report_fail(input string msg);
    errors++;
    $display("%0t %s", $time, msg);
  endtask

  task automatic finish_test(input string name, input int bad);
    tests++;
    if (bad != 0) failed_tests++;
    if (bad == 0) $display("test %s: ok", name);
    else $display("test %s: failed with %0d errors", name, bad);
  endtask

  // window model over the samples seen after reset release
  always @(posedge sys_clk) begin
    if (!sys_rst_n) begin
      mk = 0;
      m_valid = 1'b0;
    end else begin
      check_val("o_meas_valid", 32'(m_valid), 32'(o_meas_valid));
      if (o_meas_valid) begin
        meas_seen++;
        check_val("o_max", 32'(e_max), 32'(o_max));
        check_val("o_min", 32'(e_min), 32'(o_min));
        check_val("o_vpp", 32'(8'(e_max - e_min)), 32'(o_vpp));
        check_val("o_cross_count", 32'(e_cnt), 32'(o_cross_count));
      end
      if (mk == 0) begin
        m_max = i_ad_data;
        m_min = i_ad_data;
        m_cnt = '0;
      end else begin
        if (i_ad_data > m_max) m_max = i_ad_data;
        if (i_ad_data < m_min) m_min = i_ad_data;
        if (m_prev < i_trig_level && i_ad_data >= i_trig_level) m_cnt = m_cnt + 1'b1;
      end
      m_prev = i_ad_data;
      m_valid = (mk == MEAS_WINDOW - 1);  // pulse follows the last sample
      if (mk == MEAS_WINDOW - 1) begin
        e_max = m_max;
        e_min = m_min;
        e_cnt = m_cnt;
      end
      mk = (mk + 1) % MEAS_WINDOW;
    end
  end

  a_no_capture_stopped: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    stopped |-> !o_capture_done)
    else begin
      errors++;
      $display("error %0t o_capture_done expected 0 got 1", $time);
    end

  task automatic wait_vs_rise();
    int  n;
    logic last;
    bit  seen;
    last = o_vs;
    seen = 1'b0;
    for (n = 0; n < 2 * H_TOTAL * V_TOTAL && !seen; n++) begin
      @(posedge sys_clk);
      seen = o_vs && !last;
      last = o_vs;
    end
    if (!seen) report_fail("timeout, no rising edge on o_vs");
  endtask

  task automatic wait_done(input int limit);
    int n;
    bit seen;
    seen = 1'b0;
    for (n = 0; n < limit && !seen; n++) begin
      @(posedge sys_clk);
      seen = o_capture_done;
    end
    if (!seen) report_fail("timeout, o_capture_done never pulsed");
  endtask

  task automatic check_raster();
    int   n, run, lines, last_hs_at;
    logic pde, phs, pvs;
    bit   done;
    wait_vs_rise();
    pde = o_de;
    phs = o_hs;
    pvs = 1'b1;
    run = 0;
    lines = 0;
    last_hs_at = -1;
    done = 1'b0;
    for (n = 0; n < 2 * H_TOTAL * V_TOTAL && !done; n++) begin
      @(posedge sys_clk);
      if (o_de) run++;
      if (pde && !o_de) begin  // end of a visible line
        check_val("o_de run", H_ACTIVE, run);
        lines++;
        run = 0;
      end
      if (o_hs && !phs) begin
        if (last_hs_at >= 0) check_val("o_hs period", H_TOTAL, n - last_hs_at);
        last_hs_at = n;
      end
      if (o_vs && !pvs) done = 1'b1;
      pde = o_de;
      phs = o_hs;
      pvs = o_vs;
    end
    if (!done) report_fail("timeout, frame never ended");
    check_val("active lines", V_ACTIVE, lines);
  endtask

  // first record after a crossing when a ramp follows a const level
  task automatic build_record(input logic [7:0] c, input logic [7:0] start, input bit up,
                              input bit rising, input logic [7:0] lvl);
    logic [7:0] p, v;
    int         k, n;
    bit         hit;
    p = c;
    v = start;
    n = 0;
    hit = 1'b0;
    for (k = 0; k < 1024 && n < BUF_DEPTH; k++) begin
      if (!hit) hit = rising ? (p < lvl && v >= lvl) : (p >= lvl && v < lvl);
      if (hit) begin
        rec[n] = v;
        n++;
      end
      p = v;
      v = up ? v + 8'd1 : v - 8'd1;
    end
  endtask

  task automatic check_frame(output int grid_bad, output int trace_bad);
    int          n, x, y, e0;
    logic [5:0]  row;
    logic [23:0] exp;
    bit          trace, grid;
    grid_bad = 0;
    trace_bad = 0;
    x = 0;
    y = 0;
    wait_vs_rise();
    for (n = 0; n < 2 * H_TOTAL * V_TOTAL && y < V_ACTIVE; n++) begin
      @(posedge sys_clk);
      if (o_de) begin
        row   = ~rec[x][7:2];  // full scale on the top line
        trace = (y == int'(row));
        grid  = (x % GRID_STEP == 0) || (y % GRID_STEP == 0) ||
                (x == H_ACTIVE - 1) || (y == V_ACTIVE - 1);
        exp   = trace ? COLOR_WAVE : (grid ? COLOR_GRID : COLOR_BG);
        e0    = errors;
        check_val("o_rgb", 32'(exp), 32'(o_rgb));
        if (errors != e0) begin
          if (trace) trace_bad++;
          else grid_bad++;
        end
        x++;
        if (x == H_ACTIVE) begin
          x = 0;
          y++;
        end
      end
    end
    if (y < V_ACTIVE) report_fail("timeout, active area incomplete");
  endtask

  initial begin
    int e0, n, gbad, tbad;
    void'($urandom(32'h7df9_6235));
    sys_rst_n = 1'b0;
    i_ad_data = 8'd0;
    i_trig_level = 8'd127;
    i_deci_rate = 10'd1;
    i_trig_edge = 1'b1;
    i_run_key = 1'b0;
    mode = 2'd0;
    const_v = 8'd0;
    ramp_v = 8'd0;
    stopped = 1'b0;
    errors = 0;
    tests = 0;
    failed_tests = 0;
    meas_seen = 0;
    repeat (2) @(posedge sys_clk);
    sys_rst_n <= 1'b1;

    e0 = errors;
    @(posedge sys_clk);
    mode <= 2'd1;
    for (n = 0; n < 5 * MEAS_WINDOW && meas_seen < 3; n++) @(posedge sys_clk);
    if (meas_seen < 3) report_fail("timeout, too few o_meas_valid pulses");
    finish_test("measurement", errors - e0);

    e0 = errors;
    check_raster();
    finish_test("raster", errors - e0);

    // quiet low level until any pending record is released
    @(posedge sys_clk);
    i_trig_level <= 8'd100;
    const_v <= 8'd0;
    mode <= 2'd0;
    repeat (H_TOTAL * V_TOTAL + 200) @(posedge sys_clk);
    build_record(8'd0, 8'd0, 1'b1, 1'b1, 8'd100);
    ramp_v <= 8'd0;
    mode <= 2'd2;
    wait_done(4 * BUF_DEPTH);
    @(posedge sys_clk);
    const_v <= 8'd255;
    mode <= 2'd0;
    check_frame(gbad, tbad);
    finish_test("grid", gbad);
    finish_test("trace rising", tbad);

    @(posedge sys_clk);
    i_trig_edge <= 1'b0;
    repeat (H_TOTAL * V_TOTAL + 200) @(posedge sys_clk);
    build_record(8'd255, 8'd255, 1'b0, 1'b0, 8'd100);
    ramp_v <= 8'd255;
    mode <= 2'd3;
    wait_done(4 * BUF_DEPTH);
    @(posedge sys_clk);
    mode <= 2'd0;
    check_frame(gbad, tbad);
    finish_test("trace falling", gbad + tbad);

    e0 = errors;
    @(posedge sys_clk);
    i_run_key <= 1'b1;
    i_trig_edge <= 1'b1;
    @(posedge sys_clk);
    i_run_key <= 1'b0;
    @(posedge sys_clk);
    check_val("o_running", 32'd0, 32'(o_running));
    stopped <= 1'b1;
    ramp_v <= 8'd0;
    mode <= 2'd2;
    repeat (3 * BUF_DEPTH) @(posedge sys_clk);
    stopped <= 1'b0;
    i_run_key <= 1'b1;
    @(posedge sys_clk);
    i_run_key <= 1'b0;
    wait_done(3 * H_TOTAL * V_TOTAL);
    check_val("o_running", 32'd1, 32'(o_running));
    finish_test("run stop", errors - e0);

    $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- scope_top.f
logic/scope_pkg.sv
logic/sample_decimator.sv
logic/trigger_capture.sv
logic/wave_measure.sv
logic/video_timing.sv
logic/grid_overlay.sv
logic/wave_overlay.sv
logic/scope_top.sv
tests/scope_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := scope_tb
FILELIST  := scope_top.f
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "simulation did not finish"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir $(LOG)
